//--- bench/data_mem_model.svh
`ifndef DATA_MEM_MODEL_SVH
`define DATA_MEM_MODEL_SVH

// ==================================================
// reference state
// ==================================================
data_word_t m_global [GLOBAL_WORDS];
data_word_t m_stack  [STACK_WORDS];
led_t       m_led;
digi_t      m_digi;
data_word_t m_th;
data_word_t m_tl;
timer_cfg_t m_tcon;
logic       m_irq;

task automatic model_reset();
    foreach (m_global[i])
        m_global[i] = '0;
    foreach (m_stack[i])
        m_stack[i] = '0;
    m_led  = '0;
    m_digi = '0;
    m_th   = '0;
    m_tl   = '0;
    m_tcon = '0;
    m_irq  = 1'b0;
endtask

// expected response for a request from the address map rules
function automatic mem_rsp_t expected_rsp(input mem_req_t r, input switch_t sw);
    page_t       pg;
    word_index_t idx;
    logic        ok;
    data_word_t  word;
    mem_rsp_t    exp;
    pg   = r.addr[31:12];
    idx  = r.addr[11:2];
    ok   = 1'b0;
    word = '0;
    if (r.addr[1:0] == 2'b00)
    begin
        if (pg == GLOBAL_PAGE && int'(idx) < GLOBAL_WORDS)
        begin
            ok   = 1'b1;
            word = m_global[idx[GLOBAL_IDX_W-1:0]];
        end
        else if (pg == STACK_PAGE && int'(idx) >= 1024 - STACK_WORDS)
        begin
            ok   = 1'b1;
            word = m_stack[idx[STACK_IDX_W-1:0]];
        end
        else if (pg == PERI_PAGE)
        begin
            // offsets 0 to 5 are listed and the switch word cannot be written
            ok = (idx <= PERI_DIGI) && !(idx == PERI_SWITCH && r.wr);
            case (idx)
                PERI_TH:     word = m_th;
                PERI_TL:     word = m_tl;
                PERI_TCON:   word = data_word_t'(m_tcon);
                PERI_LED:    word = data_word_t'(m_led);
                PERI_SWITCH: word = data_word_t'(sw);
                PERI_DIGI:   word = data_word_t'(m_digi);
                default:     word = '0;
            endcase
        end
    end
    exp.accessible = (r.rd || r.wr) && ok;
    exp.rdata      = (r.rd && exp.accessible) ? word : '0;
    return exp;
endfunction

// state after the coming rising edge
task automatic model_step(input mem_req_t r);
    mem_rsp_t    v;
    page_t       pg;
    word_index_t idx;
    logic        wok;
    logic        peri_wr;
    v       = expected_rsp(r, '0);
    pg      = r.addr[31:12];
    idx     = r.addr[11:2];
    wok     = r.wr && v.accessible;
    peri_wr = wok && (pg == PERI_PAGE);
    // irq lags the flag by one edge
    m_irq = m_tcon.irq_flag && m_tcon.irq_enable;
    if (peri_wr && idx == PERI_TL)
        m_tl = r.wdata;
    else if (peri_wr && idx == PERI_TCON)
        m_tcon = timer_cfg_t'(r.wdata[2:0]);
    else if (m_tcon.enable)
    begin
        if (m_tl == '1)
        begin
            m_tl            = m_th;
            m_tcon.irq_flag = 1'b1;
        end
        else
            m_tl = m_tl + 32'd1;
    end
    if (peri_wr && idx == PERI_TH)
        m_th = r.wdata;
    if (peri_wr && idx == PERI_LED)
        m_led = r.wdata[7:0];
    if (peri_wr && idx == PERI_DIGI)
        m_digi = r.wdata[11:0];
    if (wok && pg == GLOBAL_PAGE)
        m_global[idx[GLOBAL_IDX_W-1:0]] = r.wdata;
    if (wok && pg == STACK_PAGE)
        m_stack[idx[STACK_IDX_W-1:0]] = r.wdata;
endtask

// ==================================================
// compare tasks
// ==================================================
task automatic abort_run(input string line);
    $display("%s", line);
    $display("SOME TESTS FAILED");
    $fatal(1);
endtask

task automatic check_rsp(input string name, input mem_rsp_t exp, input mem_rsp_t act);
    if (act !== exp)
        abort_run($sformatf({"mismatch in %s: expected rdata %h accessible %b,",
                             " actual rdata %h accessible %b"},
                            name, exp.rdata, exp.accessible, act.rdata, act.accessible));
endtask

task automatic check_led(input string name, input led_t exp, input led_t act);
    if (act !== exp)
        abort_run($sformatf("mismatch in %s: expected led %h, actual led %h", name, exp, act));
endtask

task automatic check_digi(input string name, input digi_t exp, input digi_t act);
    if (act !== exp)
        abort_run($sformatf("mismatch in %s: expected digi %h, actual digi %h", name, exp, act));
endtask

task automatic check_irq(input string name, input logic exp, input logic act);
    if (act !== exp)
        abort_run($sformatf("mismatch in %s: expected irq %b, actual irq %b", name, exp, act));
endtask

`endif

//--- bench/tb_data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_data_mem;
    import data_mem_pkg::*;

    localparam int RANDOM_SEED = 67426;
    // tests take about 700 cycles
    localparam int TIMEOUT_CYCLES = 5000;

    logic     clk;
    logic     reset_n;
    mem_req_t req;
    mem_rsp_t rsp;
    switch_t  switch;
    led_t     led;
    digi_t    digi;
    logic     irq;
    string    test_name;
    int       cycle_count = 0;

    `include "data_mem_model.svh"

    data_mem i_dut (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (req),
        .rsp     (rsp),
        .switch  (switch),
        .led     (led),
        .digi    (digi),
        .irq     (irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    // ==================================================
    // comparison just before each rising edge
    // ==================================================
    initial
    begin
        forever
        begin
            @(posedge clk);
            #9;
            if (!reset_n)
                model_reset();
            else
            begin
                check_rsp(test_name, expected_rsp(req, switch), rsp);
                check_led(test_name, m_led, led);
                check_digi(test_name, m_digi, digi);
                check_irq(test_name, m_irq, irq);
                model_step(req);
            end
        end
    end

    function automatic addr_t global_addr(input int k);
        return {GLOBAL_PAGE, word_index_t'(k), 2'b00};
    endfunction

    function automatic addr_t stack_addr(input int k);
        return {STACK_PAGE, word_index_t'(1024 - STACK_WORDS + k), 2'b00};
    endfunction

    function automatic addr_t peri_addr(input word_index_t off);
        return {PERI_PAGE, off, 2'b00};
    endfunction

    // one request per cycle while the switches move every cycle
    task automatic issue(input logic rd, input logic wr,
                         input addr_t addr, input data_word_t wdata);
        @(posedge clk);
        #1;
        req    = {rd, wr, addr, wdata};
        switch = switch_t'($urandom);
    endtask

    task automatic write_read_back(input addr_t addr);
        issue(1'b0, 1'b1, addr, $urandom);
        issue(1'b1, 1'b0, addr, '0);
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    initial
    begin
        addr_t a;
        addr_t last_addr;
        logic  have_wr;
        void'($urandom(RANDOM_SEED));
        reset_n   = 1'b0;
        req       = '0;
        switch    = '0;
        test_name = "reset";
        have_wr   = 1'b0;
        last_addr = '0;
        repeat (4) @(posedge clk);
        #1;
        reset_n = 1'b1;

        test_name = "after reset";
        for (int k = 0; k < GLOBAL_WORDS; k++)
            issue(1'b1, 1'b0, global_addr(k), '0);
        for (int k = 0; k < STACK_WORDS; k++)
            issue(1'b1, 1'b0, stack_addr(k), '0);

        test_name = "ram traffic";
        for (int i = 0; i < 400; i++)
        begin
            if (have_wr)
            begin
                issue(1'b1, 1'b0, last_addr, '0);
                have_wr = 1'b0;
            end
            else
            begin
                a = ($urandom % 2 == 0) ? global_addr($urandom % GLOBAL_WORDS)
                                        : stack_addr($urandom % STACK_WORDS);
                if ($urandom % 2 == 0)
                begin
                    issue(1'b0, 1'b1, a, $urandom);
                    have_wr   = 1'b1;
                    last_addr = a;
                end
                else
                    issue(1'b1, 1'b0, a, '0);
            end
        end

        test_name = "misaligned";
        for (int k = 1; k < 4; k++)
        begin
            write_read_back(global_addr(1) + k);
            write_read_back(stack_addr(5) + k);
            write_read_back(peri_addr(PERI_LED) + k);
        end
        issue(1'b1, 1'b0, global_addr(1), '0);
        issue(1'b1, 1'b0, stack_addr(5), '0);
        test_name = "global out of range";
        write_read_back(global_addr(32));
        write_read_back(global_addr(1023));
        issue(1'b1, 1'b0, global_addr(0), '0);
        issue(1'b1, 1'b0, global_addr(31), '0);
        test_name = "stack below range";
        write_read_back({STACK_PAGE, 10'd991, 2'b00});
        write_read_back({STACK_PAGE, 10'd960, 2'b00});
        issue(1'b1, 1'b0, stack_addr(0), '0);
        issue(1'b1, 1'b0, stack_addr(31), '0);
        test_name = "unmapped page";
        write_read_back({20'h10011, 10'd0, 2'b00});
        issue(1'b1, 1'b0, global_addr(0), '0);
        test_name = "switch write";
        write_read_back(peri_addr(PERI_SWITCH));
        test_name = "unlisted offset";
        write_read_back(peri_addr(10'd6));
        write_read_back(peri_addr(10'h3ff));
        for (int k = 0; k < 6; k++)
            issue(1'b1, 1'b0, peri_addr(word_index_t'(k)), '0);

        test_name = "led digi switch";
        repeat (20)
        begin
            write_read_back(peri_addr(PERI_LED));
            write_read_back(peri_addr(PERI_DIGI));
            issue(1'b1, 1'b0, peri_addr(PERI_SWITCH), '0);
        end

        test_name = "timer load";
        issue(1'b0, 1'b1, peri_addr(PERI_TH), 32'hffff_fff0);
        issue(1'b0, 1'b1, peri_addr(PERI_TL), 32'hffff_fff8);
        issue(1'b1, 1'b0, peri_addr(PERI_TH), '0);
        issue(1'b1, 1'b0, peri_addr(PERI_TL), '0);
        test_name = "timer count";
        issue(1'b0, 1'b1, peri_addr(PERI_TCON), 32'h3);
        repeat (40) issue(1'b1, 1'b0, peri_addr(PERI_TL), '0);
        test_name = "timer irq clear";
        issue(1'b0, 1'b1, peri_addr(PERI_TCON), 32'h3);
        repeat (4) issue(1'b1, 1'b0, peri_addr(PERI_TCON), '0);
        test_name = "timer write priority";
        issue(1'b0, 1'b1, peri_addr(PERI_TL), 32'hffff_ffff);
        repeat (3) issue(1'b1, 1'b0, peri_addr(PERI_TL), '0);
        issue(1'b0, 1'b1, peri_addr(PERI_TCON), 32'h0);
        repeat (4) issue(1'b1, 1'b0, peri_addr(PERI_TL), '0);

        issue(1'b0, 1'b0, '0, '0);
        repeat (2) @(posedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  wire                          clk,
    input  wire                          reset_n,
    input  wire data_mem_pkg::mem_req_t  req,
    output data_mem_pkg::mem_rsp_t       rsp,
    input  wire data_mem_pkg::switch_t   switch,
    output data_mem_pkg::led_t           led,
    output data_mem_pkg::digi_t          digi,
    output logic                         irq
);
    import data_mem_pkg::*;

    page_t       page;
    word_index_t index;
    logic        aligned;
    logic        access;
    logic        global_hit;
    logic        stack_hit;
    logic        peri_sel;
    logic        global_we;
    logic        stack_we;
    data_word_t  global_rdata;
    data_word_t  stack_rdata;
    data_word_t  peri_rdata;
    logic        peri_acc;
    data_word_t  src_rdata;
    logic        src_ok;

    // ==================================================
    // address split and page decode
    // ==================================================
    assign page    = req.addr[ADDR_W-1:ADDR_W-PAGE_W];
    assign index   = req.addr[ADDR_W-PAGE_W-1:2];
    assign aligned = (req.addr[1:0] == 2'b00);
    assign access  = req.rd || req.wr;

    assign global_hit = aligned && (page == GLOBAL_PAGE) && (index < GLOBAL_WORDS);
    assign stack_hit  = aligned && (page == STACK_PAGE) && (index >= STACK_BASE);
    // offset checks are left to the peripheral block
    assign peri_sel   = aligned && (page == PERI_PAGE);

    assign global_we = req.wr && global_hit;
    assign stack_we  = req.wr && stack_hit;

    word_ram #(
        .DEPTH (GLOBAL_WORDS)
    ) u_global_ram (
        .clk     (clk),
        .reset_n (reset_n),
        .we      (global_we),
        .windex  (index[GLOBAL_IDX_W-1:0]),
        .wdata   (req.wdata),
        .rindex  (index[GLOBAL_IDX_W-1:0]),
        .rdata   (global_rdata)
    );

    // stack words map onto the low index bits
    word_ram #(
        .DEPTH (STACK_WORDS)
    ) u_stack_ram (
        .clk     (clk),
        .reset_n (reset_n),
        .we      (stack_we),
        .windex  (index[STACK_IDX_W-1:0]),
        .wdata   (req.wdata),
        .rindex  (index[STACK_IDX_W-1:0]),
        .rdata   (stack_rdata)
    );

    peripheral u_peripheral (
        .clk        (clk),
        .reset_n    (reset_n),
        .sel        (peri_sel),
        .rd         (req.rd),
        .wr         (req.wr),
        .offset     (index),
        .wdata      (req.wdata),
        .rdata      (peri_rdata),
        .accessible (peri_acc),
        .switch     (switch),
        .led        (led),
        .digi       (digi),
        .irq        (irq)
    );

    // ==================================================
    // response
    // ==================================================
    always_comb
    begin
        src_rdata = '0;
        src_ok    = 1'b0;
        if (global_hit)
        begin
            src_rdata = global_rdata;
            src_ok    = access;
        end
        else if (stack_hit)
        begin
            src_rdata = stack_rdata;
            src_ok    = access;
        end
        else if (peri_sel)
        begin
            src_rdata = peri_rdata;
            src_ok    = peri_acc;
        end

        rsp.accessible = src_ok;
        rsp.rdata      = (req.rd && src_ok) ? src_rdata : '0;
    end

    // the memory stage issues at most one direction per cycle
    rd_wr_exclusive: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(req.rd && req.wr)
    );

endmodule

`default_nettype wire

//--- design/data_mem_pkg.sv
`default_nettype none

package data_mem_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 32;
    localparam int PAGE_W   = 20;
    localparam int INDEX_W  = 10;
    localparam int LED_W    = 8;
    localparam int SWITCH_W = 8;
    localparam int DIGI_W   = 12;

    typedef logic [DATA_W-1:0]   data_word_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [PAGE_W-1:0]   page_t;
    typedef logic [INDEX_W-1:0]  word_index_t;
    typedef logic [LED_W-1:0]    led_t;
    typedef logic [SWITCH_W-1:0] switch_t;
    // 4 anode enables above 8 segments
    typedef logic [DIGI_W-1:0]   digi_t;

    // ==================================================
    // bus structs
    // ==================================================
    typedef struct packed {
        logic       rd;
        logic       wr;
        addr_t      addr;
        data_word_t wdata;
    } mem_req_t;

    typedef struct packed {
        data_word_t rdata;
        logic       accessible;
    } mem_rsp_t;

    // TCON as seen on the bus, enable in bit 0
    typedef struct packed {
        logic irq_flag;
        logic irq_enable;
        logic enable;
    } timer_cfg_t;

    // ==================================================
    // address map
    // ==================================================
    localparam page_t GLOBAL_PAGE = 20'h10010;
    localparam page_t STACK_PAGE  = 20'h7ffff;
    localparam page_t PERI_PAGE   = 20'h40000;

    localparam int GLOBAL_WORDS = 32;
    localparam int STACK_WORDS  = 32;
    localparam int PAGE_WORDS   = 1 << INDEX_W;
    localparam int GLOBAL_IDX_W = $clog2(GLOBAL_WORDS);
    localparam int STACK_IDX_W  = $clog2(STACK_WORDS);

    // stack occupies the top of its page
    localparam word_index_t STACK_BASE = word_index_t'(PAGE_WORDS - STACK_WORDS);

    // peripheral word offsets
    localparam word_index_t PERI_TH     = 10'd0;
    localparam word_index_t PERI_TL     = 10'd1;
    localparam word_index_t PERI_TCON   = 10'd2;
    localparam word_index_t PERI_LED    = 10'd3;
    localparam word_index_t PERI_SWITCH = 10'd4;
    localparam word_index_t PERI_DIGI   = 10'd5;

endpackage

`default_nettype wire

//--- design/peripheral.sv
`timescale 1ns/1ps
`default_nettype none

module peripheral (
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire                            sel,
    input  wire                            rd,
    input  wire                            wr,
    input  wire data_mem_pkg::word_index_t offset,
    input  wire data_mem_pkg::data_word_t  wdata,
    output data_mem_pkg::data_word_t       rdata,
    output logic                           accessible,
    input  wire data_mem_pkg::switch_t     switch,
    output data_mem_pkg::led_t             led,
    output data_mem_pkg::digi_t            digi,
    output logic                           irq
);
    import data_mem_pkg::*;

    logic       hit_th;
    logic       hit_tl;
    logic       hit_tcon;
    logic       hit_led;
    logic       hit_switch;
    logic       hit_digi;
    logic       listed;
    logic       rd_ok;
    logic       wr_ok;
    logic       wr_th;
    logic       wr_tl;
    logic       wr_tcon;
    logic       wr_led;
    logic       wr_digi;
    data_word_t th;
    data_word_t tl;
    timer_cfg_t tcon;

    // ==================================================
    // offset decode
    // ==================================================
    assign hit_th     = (offset == PERI_TH);
    assign hit_tl     = (offset == PERI_TL);
    assign hit_tcon   = (offset == PERI_TCON);
    assign hit_led    = (offset == PERI_LED);
    assign hit_switch = (offset == PERI_SWITCH);
    assign hit_digi   = (offset == PERI_DIGI);

    assign listed = hit_th || hit_tl || hit_tcon || hit_led || hit_switch || hit_digi;

    // switches are read only
    assign rd_ok = sel && rd && listed;
    assign wr_ok = sel && wr && listed && !hit_switch;

    assign accessible = rd_ok || wr_ok;

    assign wr_th   = wr_ok && hit_th;
    assign wr_tl   = wr_ok && hit_tl;
    assign wr_tcon = wr_ok && hit_tcon;
    assign wr_led  = wr_ok && hit_led;
    assign wr_digi = wr_ok && hit_digi;

    timer u_timer (
        .clk     (clk),
        .reset_n (reset_n),
        .wr_th   (wr_th),
        .wr_tl   (wr_tl),
        .wr_tcon (wr_tcon),
        .wdata   (wdata),
        .th      (th),
        .tl      (tl),
        .tcon    (tcon),
        .irq     (irq)
    );

    // ==================================================
    // output registers
    // ==================================================
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            led  <= '0;
            digi <= '0;
        end
        else
        begin
            if (wr_led)
            begin
                led <= wdata[LED_W-1:0];
            end
            if (wr_digi)
            begin
                digi <= wdata[DIGI_W-1:0];
            end
        end
    end

    // read data, zero extended to a word
    always_comb
    begin
        case (offset)
            PERI_TH:     rdata = th;
            PERI_TL:     rdata = tl;
            PERI_TCON:   rdata = {{(DATA_W-$bits(timer_cfg_t)){1'b0}}, tcon};
            PERI_LED:    rdata = {{(DATA_W-LED_W){1'b0}}, led};
            PERI_SWITCH: rdata = {{(DATA_W-SWITCH_W){1'b0}}, switch};
            PERI_DIGI:   rdata = {{(DATA_W-DIGI_W){1'b0}}, digi};
            default:     rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/timer.sv
`timescale 1ns/1ps
`default_nettype none

module timer (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire                           wr_th,
    input  wire                           wr_tl,
    input  wire                           wr_tcon,
    input  wire data_mem_pkg::data_word_t wdata,
    output data_mem_pkg::data_word_t      th,
    output data_mem_pkg::data_word_t      tl,
    output data_mem_pkg::timer_cfg_t      tcon,
    output logic                          irq
);
    import data_mem_pkg::*;

    logic overflow;
    logic count_en;

    assign overflow = (tl == '1);

    // a bus write to TL or TCON holds the count for that edge
    assign count_en = tcon.enable && !wr_tl && !wr_tcon;

    // ==================================================
    // reload and count registers
    // ==================================================
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            th <= '0;
        end
        else if (wr_th)
        begin
            th <= wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tl <= '0;
        end
        else if (wr_tl)
        begin
            tl <= wdata;
        end
        else if (count_en)
        begin
            tl <= overflow ? th : tl + data_word_t'(1);
        end
    end

    // ==================================================
    // control bits and interrupt
    // ==================================================
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tcon <= '0;
        end
        else if (wr_tcon)
        begin
            tcon <= timer_cfg_t'(wdata[$bits(timer_cfg_t)-1:0]);
        end
        else if (count_en && overflow)
        begin
            // sticky until software rewrites TCON
            tcon.irq_flag <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            irq <= 1'b0;
        end
        else
        begin
            irq <= tcon.irq_flag && tcon.irq_enable;
        end
    end

    irq_follows_flag: assert property (
        @(posedge clk) disable iff (!reset_n)
        irq |-> $past(tcon.irq_flag)
    );

endmodule

`default_nettype wire

//--- design/word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
    parameter int DEPTH = 32
) (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire                           we,
    input  wire [$clog2(DEPTH)-1:0]       windex,
    input  wire data_mem_pkg::data_word_t wdata,
    input  wire [$clog2(DEPTH)-1:0]       rindex,
    output data_mem_pkg::data_word_t      rdata
);
    import data_mem_pkg::*;

    data_word_t mem [DEPTH];

    // whole array clears while reset is held
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (we)
        begin
            mem[windex] <= wdata;
        end
    end

    assign rdata = mem[rindex];

    // the caller must keep write indices inside the array
    windex_in_range: assert property (
        @(posedge clk) disable iff (!reset_n)
        we |-> (windex < DEPTH)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the data memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_data_mem -o tb_data_mem -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_data_mem 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- verilog.f
+incdir+bench
design/data_mem_pkg.sv
design/word_ram.sv
design/timer.sv
design/peripheral.sv
design/data_mem.sv
bench/tb_data_mem.sv
